// ==== include/rvvi_defines.svh ====
`ifndef RVVI_DEFINES_SVH
`define RVVI_DEFINES_SVH

//////////////////////////////////////////////////////////////
// Data path widths
//////////////////////////////////////////////////////////////
`define RVVI_XLEN             32
`define RVVI_NUM_GPR          32
`define RVVI_NUM_CSR          8
`define RVVI_ORDER_W          64

// Field widths of the retirement record
`define RVVI_EXC_CAUSE_W      6
`define RVVI_INTR_CAUSE_W     11
`define RVVI_DBG_CAUSE_W      3
`define RVVI_GPR_ADDR_W       5

//////////////////////////////////////////////////////////////
// Traced CSR slots, in array order
//////////////////////////////////////////////////////////////
`define RVVI_CSR_IDX_MSTATUS  0
`define RVVI_CSR_IDX_MIE      1
`define RVVI_CSR_IDX_MTVEC    2
`define RVVI_CSR_IDX_MSCRATCH 3
`define RVVI_CSR_IDX_MEPC     4
`define RVVI_CSR_IDX_MCAUSE   5
`define RVVI_CSR_IDX_MTVAL    6
`define RVVI_CSR_IDX_DPC      7

//////////////////////////////////////////////////////////////
// Cause codes
//////////////////////////////////////////////////////////////
// Fetch fault raised outside the core model
`define RVVI_CAUSE_IBUS_FAULT  48
`define RVVI_CAUSE_NMI_LOAD    1024
`define RVVI_CAUSE_NMI_STORE   1025
`define RVVI_DBG_CAUSE_HALTREQ 3

// MSI, MTI, MEI and the sixteen local interrupts
`define RVVI_IRQ_MASK          32'hFFFF_0888

// Net event queue
`define RVVI_EVQ_DEPTH         8

`endif

// ==== src/rvviPkg.sv ====
`default_nettype none

`include "rvvi_defines.svh"

package rvviPkg;

   //////////////////////////////////////////////////////////////
   // Enumerations
   //////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      CSR_MSTATUS  = `RVVI_CSR_IDX_MSTATUS,
      CSR_MIE      = `RVVI_CSR_IDX_MIE,
      CSR_MTVEC    = `RVVI_CSR_IDX_MTVEC,
      CSR_MSCRATCH = `RVVI_CSR_IDX_MSCRATCH,
      CSR_MEPC     = `RVVI_CSR_IDX_MEPC,
      CSR_MCAUSE   = `RVVI_CSR_IDX_MCAUSE,
      CSR_MTVAL    = `RVVI_CSR_IDX_MTVAL,
      CSR_DPC      = `RVVI_CSR_IDX_DPC
   } csrIdxE;

   // Lower value issues first; the cause goes out ahead of the NMI level
   typedef enum logic [2:0] {
      NET_HALTREQ,
      NET_NMI_CAUSE,
      NET_NMI,
      NET_IBUS_FAULT,
      NET_IRQ
   } netIdE;

   //////////////////////////////////////////////////////////////
   // Retirement record from the core
   //////////////////////////////////////////////////////////////
   typedef struct packed {
      logic                           trap;
      logic                           exception;
      logic [`RVVI_EXC_CAUSE_W-1:0]   exceptionCause;
   } trapT;

   typedef struct packed {
      logic                           intr;
      logic                           interrupt;
      logic [`RVVI_INTR_CAUSE_W-1:0]  cause;
   } intrT;

   typedef struct packed {
      logic                           valid;
      logic [`RVVI_ORDER_W-1:0]       order;
      logic [`RVVI_XLEN-1:0]          insn;
      trapT                           trap;
      intrT                           intr;
      logic [1:0]                     mode;
      logic [1:0]                     ixl;
      logic [`RVVI_XLEN-1:0]          pcRdata;
      logic [`RVVI_XLEN-1:0]          pcWdata;
      logic [`RVVI_GPR_ADDR_W-1:0]    rd1Addr;
      logic [`RVVI_XLEN-1:0]          rd1Wdata;
      logic [`RVVI_DBG_CAUSE_W-1:0]   dbg;
      logic                           dbgMode;
      // Bit 0 NMI pending, bit 1 load (0) or store (1)
      logic [1:0]                     nmip;
   } retireT;

   typedef struct packed {
      logic [`RVVI_XLEN-1:0]          rdata;
      logic [`RVVI_XLEN-1:0]          wdata;
      logic [`RVVI_XLEN-1:0]          wmask;
   } csrPortT;

   typedef struct packed {
      netIdE                          id;
      logic [`RVVI_XLEN-1:0]          value;
   } netEventT;

   //////////////////////////////////////////////////////////////
   // Registered trace
   //////////////////////////////////////////////////////////////
   typedef struct packed {
      logic                           valid;
      logic [`RVVI_ORDER_W-1:0]       order;
      logic [`RVVI_XLEN-1:0]          insn;
      logic                           trap;
      logic                           intr;
      logic [1:0]                     mode;
      logic [1:0]                     ixl;
      logic [`RVVI_XLEN-1:0]          pcRdata;
      logic [`RVVI_XLEN-1:0]          pcWdata;
      logic [`RVVI_NUM_GPR-1:0]       xWb;
      logic [`RVVI_XLEN-1:0]          xWdata;
   } traceOutT;

endpackage

`default_nettype wire

// ==== src/retireTrace.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rvvi_defines.svh"

module retireTrace (
   input  wire                  rvvi,
   input  wire                  rst_i,
   input  wire rvviPkg::retireT retire_i,
   output rvviPkg::traceOutT    trace_o
);

   logic                     fetchTrap;
   logic [`RVVI_NUM_GPR-1:0] wbMask;

   //////////////////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////////////////

   // Only the externally generated fetch fault is flagged as a trap,
   // every other trap is predicted by the reference model
   assign fetchTrap = retire_i.trap.trap &&
                      (retire_i.trap.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);

   // x0 is never reported as written
   assign wbMask = (retire_i.rd1Addr != '0) ?
                   (`RVVI_NUM_GPR'(1) << retire_i.rd1Addr) : '0;

   //////////////////////////////////////////////////////////////
   // Trace register
   //////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         trace_o.valid <= 1'b0;
      end else begin
         trace_o.valid <= retire_i.valid;
      end

      trace_o.order   <= retire_i.order;
      trace_o.insn    <= retire_i.insn;
      trace_o.trap    <= fetchTrap;
      trace_o.intr    <= retire_i.intr.intr;
      trace_o.mode    <= retire_i.mode;
      trace_o.ixl     <= retire_i.ixl;
      trace_o.pcRdata <= retire_i.pcRdata;
      trace_o.pcWdata <= retire_i.pcWdata;
      trace_o.xWb     <= wbMask;
      trace_o.xWdata  <= retire_i.rd1Wdata;
   end

   //////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////

   // A single destination register per retirement, seen one cycle later
   xWbOneHot: assert property (
      @(posedge rvvi) disable iff (rst_i)
      retire_i.valid |=> trace_o.valid && $onehot0(trace_o.xWb)
   ) else $error("xWb has more than one bit set");

endmodule

`default_nettype wire

// ==== src/csrTrace.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rvvi_defines.svh"

module csrTrace (
   input  wire                      rvvi,
   input  wire                      rst_i,
   input  wire                      retireValid_i,
   input  wire rvviPkg::csrPortT    csr_i [`RVVI_NUM_CSR],
   output logic [`RVVI_XLEN-1:0]    csrValue_o [`RVVI_NUM_CSR],
   output logic [`RVVI_NUM_CSR-1:0] csrWb_o
);

   logic [`RVVI_XLEN-1:0] merged [`RVVI_NUM_CSR];

   //////////////////////////////////////////////////////////////
   // Merge
   //////////////////////////////////////////////////////////////

   // Written bits come from wdata, the rest keep the value read
   always_comb begin
      for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
         merged[i] = (csr_i[i].wdata & csr_i[i].wmask) |
                     (csr_i[i].rdata & ~csr_i[i].wmask);
      end
   end

   //////////////////////////////////////////////////////////////
   // Value and change flags
   //////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            csrValue_o[i] <= '0;
         end
         csrWb_o <= '0;
      end else if (retireValid_i) begin
         for (int i = 0; i < `RVVI_NUM_CSR; i++) begin
            // Compare against the value from the previous retirement
            csrWb_o[i]    <= (merged[i] != csrValue_o[i]);
            csrValue_o[i] <= merged[i];
         end
      end
   end

   //////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////

   // Idle cycles hold the flags, so none can go high between retirements
   noIdleFlag: assert property (
      @(posedge rvvi) disable iff (rst_i)
      !retireValid_i |=> (csrWb_o & ~$past(csrWb_o)) == '0
   ) else $error("CSR changed flag rose without a retirement");

endmodule

`default_nettype wire

// ==== src/eventMonitor.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rvvi_defines.svh"

module eventMonitor (
   input  wire                  rvvi,
   input  wire                  rst_i,
   input  wire rvviPkg::retireT retire_i,
   input  wire [`RVVI_XLEN-1:0] irq_i,
   output rvviPkg::netEventT    event_o,
   output logic                 push_o,
   input  wire                  full_i
);

   localparam int NUM_NET = 5;
   localparam int XW      = `RVVI_XLEN;

   // Tracked states
   logic [`RVVI_ORDER_W-1:0] lastOrder;
   logic                     orderSeen;
   logic                     haltState;
   logic                     nmiState;
   logic [XW-1:0]            nmiCause;
   logic                     faultState;
   logic [XW-1:0]            irqState;

   // Decoded current cycle
   logic                     newRetire;
   logic                     haltReq;
   logic                     nmiReq;
   logic                     faultReq;
   logic [XW-1:0]            intrCause;
   logic [XW-1:0]            irqMasked;

   // Pending entries, one per net event kind
   logic [NUM_NET-1:0]       raise;
   logic [XW-1:0]            raiseVal [NUM_NET];
   logic [NUM_NET-1:0]       pendValid;
   logic [XW-1:0]            pendVal [NUM_NET];
   logic [NUM_NET-1:0]       grant;

   //////////////////////////////////////////////////////////////
   // Edge detection
   //////////////////////////////////////////////////////////////
   always_comb begin
      // A replayed order number is not a new retirement
      newRetire = retire_i.valid && (!orderSeen || (retire_i.order != lastOrder));
      haltReq   = (retire_i.dbg == `RVVI_DBG_CAUSE_HALTREQ) && retire_i.dbgMode;
      intrCause = XW'(retire_i.intr.cause);
      nmiReq    = (retire_i.intr.intr && retire_i.intr.interrupt &&
                   ((intrCause == `RVVI_CAUSE_NMI_LOAD) ||
                    (intrCause == `RVVI_CAUSE_NMI_STORE))) || retire_i.nmip[0];
      faultReq  = retire_i.trap.trap && retire_i.trap.exception &&
                  (retire_i.trap.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);
      irqMasked = irq_i & `RVVI_IRQ_MASK;

      raise[rvviPkg::NET_HALTREQ]       = newRetire && (haltReq != haltState);
      raise[rvviPkg::NET_NMI_CAUSE]     = newRetire && nmiReq && (intrCause != nmiCause);
      raise[rvviPkg::NET_NMI]           = newRetire && (nmiReq != nmiState);
      raise[rvviPkg::NET_IBUS_FAULT]    = newRetire && (faultReq != faultState);
      raise[rvviPkg::NET_IRQ]           = (irqMasked != irqState);

      raiseVal[rvviPkg::NET_HALTREQ]    = XW'(haltReq);
      raiseVal[rvviPkg::NET_NMI_CAUSE]  = intrCause;
      raiseVal[rvviPkg::NET_NMI]        = XW'(nmiReq);
      raiseVal[rvviPkg::NET_IBUS_FAULT] = XW'(faultReq);
      raiseVal[rvviPkg::NET_IRQ]        = irqMasked;
   end

   //////////////////////////////////////////////////////////////
   // Priority pick with the lowest id first
   //////////////////////////////////////////////////////////////
   always_comb begin
      grant         = '0;
      event_o.id    = rvviPkg::NET_HALTREQ;
      event_o.value = '0;
      for (int i = NUM_NET - 1; i >= 0; i--) begin
         if (pendValid[i]) begin
            grant         = NUM_NET'(1) << i;
            event_o.id    = rvviPkg::netIdE'(i);
            event_o.value = pendVal[i];
         end
      end
      push_o = (pendValid != '0) && !full_i;
   end

   //////////////////////////////////////////////////////////////
   // State and pending registers
   //////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         orderSeen  <= 1'b0;
         lastOrder  <= '0;
         haltState  <= 1'b0;
         nmiState   <= 1'b0;
         nmiCause   <= '0;
         faultState <= 1'b0;
         irqState   <= '0;
         pendValid  <= '0;
      end else begin
         if (newRetire) begin
            orderSeen  <= 1'b1;
            lastOrder  <= retire_i.order;
            haltState  <= haltReq;
            nmiState   <= nmiReq;
            faultState <= faultReq;
            if (nmiReq) begin
               nmiCause <= intrCause;
            end
         end
         irqState <= irqMasked;
         // A fresh change re-arms the entry even in the cycle it is sent
         pendValid <= (pendValid & ~(push_o ? grant : '0)) | raise;
      end
   end

   // Latest value wins while an entry waits for room in the queue
   always_ff @(posedge rvvi) begin
      for (int i = 0; i < NUM_NET; i++) begin
         if (raise[i]) begin
            pendVal[i] <= raiseVal[i];
         end
      end
   end

   // Entries wait while the queue is full
   pendHeldWhileFull: assert property (
      @(posedge rvvi) disable iff (rst_i)
      full_i |=> (pendValid & $past(pendValid)) == $past(pendValid)
   ) else $error("Pending net event dropped while the queue was full");

endmodule

`default_nettype wire

// ==== src/netEventFifo.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rvvi_defines.svh"

module netEventFifo (
   input  wire                    rvvi,
   input  wire                    rst_i,
   input  wire                    push_i,
   input  wire rvviPkg::netEventT event_i,
   output logic                   full_o,
   output rvviPkg::netEventT      netEvent_o,
   output logic                   netValid_o,
   input  wire                    netReady_i
);

   localparam int DEPTH = `RVVI_EVQ_DEPTH;
   localparam int AW    = $clog2(DEPTH);
   localparam int CW    = AW + 1;
   localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

   rvviPkg::netEventT mem [DEPTH];
   logic [AW-1:0]     wrPtr;
   logic [AW-1:0]     rdPtr;
   logic [CW-1:0]     count;
   logic              wr;
   logic              pop;

   assign full_o     = (count == CW'(DEPTH));
   assign netValid_o = (count != '0);
   assign netEvent_o = mem[rdPtr];

   assign wr  = push_i && !full_o;
   assign pop = netValid_o && netReady_i;

   //////////////////////////////////////////////////////////////
   // Pointers and occupancy
   //////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (wr) begin
            wrPtr <= (wrPtr == LAST) ? '0 : wrPtr + 1'b1;
         end
         if (pop) begin
            rdPtr <= (rdPtr == LAST) ? '0 : rdPtr + 1'b1;
         end
         case ({wr, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage
   always_ff @(posedge rvvi) begin
      if (wr) begin
         mem[wrPtr] <= event_i;
      end
   end

   //////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////
   noOverflow: assert property (
      @(posedge rvvi) disable iff (rst_i)
      !(push_i && full_o)
   ) else $error("Net event queue overflow");

   noEmptyPop: assert property (
      @(posedge rvvi) disable iff (rst_i)
      (netReady_i && (count == '0)) |=> (rdPtr == $past(rdPtr))
   ) else $error("Net event queue popped while empty");

   // Head entry holds until the consumer takes it
   holdUntilTaken: assert property (
      @(posedge rvvi) disable iff (rst_i)
      (netValid_o && !netReady_i) |=> netValid_o && $stable(netEvent_o)
   ) else $error("Net event changed before transfer");

endmodule

`default_nettype wire

// ==== src/rvviTraceTop.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rvvi_defines.svh"

module rvviTraceTop (
   input  wire                           rvvi,
   input  wire                           rst_i,
   input  wire rvviPkg::retireT          retire_i,
   input  wire rvviPkg::csrPortT         csr_i [`RVVI_NUM_CSR],
   input  wire [`RVVI_XLEN-1:0]          irq_i,
   output rvviPkg::traceOutT             trace_o,
   output logic [`RVVI_XLEN-1:0]         csrValue_o [`RVVI_NUM_CSR],
   output logic [`RVVI_NUM_CSR-1:0]      csrWb_o,
   output rvviPkg::netEventT             netEvent_o,
   output logic                          netValid_o,
   input  wire                           netReady_i
);

   // Monitor to queue handoff
   rvviPkg::netEventT monEvent;
   logic              monPush;
   logic              queueFull;

   //////////////////////////////////////////////////////////////
   // Synchronous trace
   //////////////////////////////////////////////////////////////
   retireTrace retireTrace_i (
      .rvvi     (rvvi),
      .rst_i    (rst_i),
      .retire_i (retire_i),
      .trace_o  (trace_o)
   );

   csrTrace csrTrace_i (
      .rvvi          (rvvi),
      .rst_i         (rst_i),
      .retireValid_i (retire_i.valid),
      .csr_i         (csr_i),
      .csrValue_o    (csrValue_o),
      .csrWb_o       (csrWb_o)
   );

   //////////////////////////////////////////////////////////////
   // Asynchronous net events
   //////////////////////////////////////////////////////////////
   eventMonitor eventMonitor_i (
      .rvvi     (rvvi),
      .rst_i    (rst_i),
      .retire_i (retire_i),
      .irq_i    (irq_i),
      .event_o  (monEvent),
      .push_o   (monPush),
      .full_i   (queueFull)
   );

   netEventFifo netEventFifo_i (
      .rvvi       (rvvi),
      .rst_i      (rst_i),
      .push_i     (monPush),
      .event_i    (monEvent),
      .full_o     (queueFull),
      .netEvent_o (netEvent_o),
      .netValid_o (netValid_o),
      .netReady_i (netReady_i)
   );

endmodule

`default_nettype wire

// ==== tb/tbClock.sv ====
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
   parameter int HALF_PERIOD  = 50,
   parameter int RESET_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // Reset held over the first rising edges, released on an edge
   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== tb/rvviTraceTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rvvi_defines.svh"

module rvviTraceTb;

   localparam int NUM_CSR = `RVVI_NUM_CSR;
   localparam int NUM_NET = 5;
   localparam logic [4:0] EV_HALT  = 5'(1) << rvviPkg::NET_HALTREQ;
   localparam logic [4:0] EV_CAUSE = 5'(1) << rvviPkg::NET_NMI_CAUSE;
   localparam logic [4:0] EV_NMI   = 5'(1) << rvviPkg::NET_NMI;
   localparam logic [4:0] EV_FAULT = 5'(1) << rvviPkg::NET_IBUS_FAULT;
   localparam logic [4:0] EV_IRQ   = 5'(1) << rvviPkg::NET_IRQ;

   // One stimulus row and the net events it should raise
   typedef struct {
      rvviPkg::retireT ret;
      logic [31:0]     irq;
      logic            csrNew;
      logic            gaps;
      logic [4:0]      expRaise;
   } rowT;

   logic                rvvi;
   logic                rst_i;
   rvviPkg::retireT     retire;
   rvviPkg::csrPortT    csrIn [NUM_CSR];
   logic [31:0]         irq;
   logic                netReady;
   rvviPkg::traceOutT   traceOut;
   logic [31:0]         csrValue [NUM_CSR];
   logic [NUM_CSR-1:0]  csrWb;
   rvviPkg::netEventT   netEvent;
   logic                netValid;

   rowT                 rows [$];
   integer              seed = 32'h53af;
   int                  timeoutLimit = 1000000;
   int                  cycles = 0;
   int                  occ;
   logic [4:0]          curExpRaise;

   //////////////////////////////////////////////////////////////
   // Reference model state
   //////////////////////////////////////////////////////////////
   logic                modelLive = 1'b0;
   rvviPkg::traceOutT   expTrace;
   logic [31:0]         expCsr [NUM_CSR];
   logic [NUM_CSR-1:0]  expWb;
   logic                mSeen;
   logic                mHalt;
   logic                mNmi;
   logic                mFault;
   logic [63:0]         mLastOrder;
   logic [31:0]         mCause;
   logic [31:0]         mIrq;
   logic [4:0]          mPend;
   logic [31:0]         mPendVal [NUM_NET];
   rvviPkg::netEventT   expQ [$];
   logic                waiting;
   rvviPkg::netEventT   heldEvent;

   tbClock tbClock_i (
      .clk_o (rvvi),
      .rst_o (rst_i)
   );

   rvviTraceTop rvviTraceTop_i (
      .rvvi       (rvvi),
      .rst_i      (rst_i),
      .retire_i   (retire),
      .csr_i      (csrIn),
      .irq_i      (irq),
      .trace_o    (traceOut),
      .csrValue_o (csrValue),
      .csrWb_o    (csrWb),
      .netEvent_o (netEvent),
      .netValid_o (netValid),
      .netReady_i (netReady)
   );

   task automatic reportFail(input string what);
      $display("%s", what);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic checkValue(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      if (got !== exp) begin
         reportFail($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   // Plain retirement with fields derived from the order number
   function automatic rvviPkg::retireT makeRetire(input logic [63:0] order,
                                                  input logic [4:0] rd);
      rvviPkg::retireT r;
      r          = '0;
      r.valid    = 1'b1;
      r.order    = order;
      r.insn     = 32'h0000_0013 | (32'(rd) << 7);
      r.mode     = order[0] ? 2'b11 : 2'b00;
      r.ixl      = 2'b01;
      r.pcRdata  = 32'h8000_0000 + (order[31:0] << 2);
      r.pcWdata  = r.pcRdata + 32'd4;
      r.rd1Addr  = rd;
      r.rd1Wdata = {order[15:0], 11'h5a5, rd};
      return r;
   endfunction

   task automatic addRow(input rvviPkg::retireT r, input logic [31:0] irqV,
                         input logic csrNew, input logic gaps, input logic [4:0] expRaise);
      rowT row;
      row.ret      = r;
      row.irq      = irqV;
      row.csrNew   = csrNew;
      row.gaps     = gaps;
      row.expRaise = expRaise;
      rows.push_back(row);
   endtask

   //////////////////////////////////////////////////////////////
   // Stimulus table
   //////////////////////////////////////////////////////////////
   task automatic buildTable();
      rvviPkg::retireT r;
      rvviPkg::retireT idle;
      logic [31:0]     irqV;
      logic [4:0]      rd;
      logic [4:0]      expBits;
      idle = '0;
      irqV = '0;
      addRow(idle, irqV, 1'b1, 1'b0, '0);
      addRow(idle, irqV, 1'b1, 1'b0, '0);
      // Writes to x5, x0 and x31 with the CSR ports held for the last one
      addRow(makeRetire(64'd1, 5'd5), irqV, 1'b1, 1'b0, '0);
      addRow(makeRetire(64'd2, 5'd0), irqV, 1'b1, 1'b0, '0);
      addRow(makeRetire(64'd3, 5'd31), irqV, 1'b0, 1'b0, '0);
      // Halt request, replayed order, then release
      r = makeRetire(64'd4, 5'd1);
      r.dbg = `RVVI_DBG_CAUSE_HALTREQ;
      r.dbgMode = 1'b1;
      addRow(r, irqV, 1'b1, 1'b0, EV_HALT);
      addRow(makeRetire(64'd4, 5'd2), irqV, 1'b1, 1'b0, '0);
      addRow(makeRetire(64'd5, 5'd3), irqV, 1'b1, 1'b0, EV_HALT);
      // Load NMI, store NMI, back to normal
      r = makeRetire(64'd6, 5'd4);
      r.intr.intr = 1'b1;
      r.intr.interrupt = 1'b1;
      r.intr.cause = `RVVI_CAUSE_NMI_LOAD;
      addRow(r, irqV, 1'b1, 1'b1, EV_CAUSE | EV_NMI);
      r = makeRetire(64'd7, 5'd6);
      r.intr.intr = 1'b1;
      r.intr.interrupt = 1'b1;
      r.intr.cause = `RVVI_CAUSE_NMI_STORE;
      addRow(r, irqV, 1'b0, 1'b1, EV_CAUSE);
      addRow(makeRetire(64'd8, 5'd7), irqV, 1'b1, 1'b1, EV_NMI);
      // Fetch fault from the instruction bus
      r = makeRetire(64'd9, 5'd0);
      r.trap.trap = 1'b1;
      r.trap.exception = 1'b1;
      r.trap.exceptionCause = `RVVI_CAUSE_IBUS_FAULT;
      addRow(r, irqV, 1'b1, 1'b1, EV_FAULT);
      // An illegal instruction trap is not a fetch fault
      r = makeRetire(64'd10, 5'd8);
      r.trap.trap = 1'b1;
      r.trap.exception = 1'b1;
      r.trap.exceptionCause = 6'd2;
      addRow(r, irqV, 1'b1, 1'b1, EV_FAULT);
      // MTI toggles while bits 0 and 2 stay masked off
      irqV = 32'h0000_0080;
      addRow(idle, irqV, 1'b1, 1'b1, EV_IRQ);
      irqV = 32'h0000_0081;
      addRow(idle, irqV, 1'b0, 1'b1, '0);
      irqV = 32'h0000_0001;
      addRow(idle, irqV, 1'b0, 1'b1, EV_IRQ);
      irqV = 32'h0000_0005;
      addRow(idle, irqV, 1'b1, 1'b1, '0);
      // Several kinds raised in one cycle
      irqV = 32'h0001_0005;
      r = makeRetire(64'd11, 5'd9);
      r.nmip = 2'b01;
      addRow(r, irqV, 1'b1, 1'b1, EV_CAUSE | EV_NMI | EV_IRQ);
      r = makeRetire(64'd12, 5'd10);
      r.dbg = `RVVI_DBG_CAUSE_HALTREQ;
      r.dbgMode = 1'b1;
      r.trap.trap = 1'b1;
      r.trap.exception = 1'b1;
      r.trap.exceptionCause = `RVVI_CAUSE_IBUS_FAULT;
      addRow(r, irqV, 1'b1, 1'b1, EV_HALT | EV_NMI | EV_FAULT);
      addRow(makeRetire(64'd13, 5'd11), irqV, 1'b1, 1'b1, EV_HALT | EV_FAULT);
      // Random traffic where MEI toggles every fourth row
      for (int i = 0; i < 16; i++) begin
         rd = 5'($random(seed));
         expBits = '0;
         if (i % 4 == 3) begin
            irqV = irqV ^ 32'h0000_0800;
            expBits = EV_IRQ;
         end
         irqV = irqV ^ ($random(seed) & ~`RVVI_IRQ_MASK);
         addRow(makeRetire(64'(14 + i), rd), irqV, (i % 3) != 0, 1'b1, expBits);
      end
      timeoutLimit = rows.size() * 4 + 50;
   endtask

   task automatic driveRow(input rowT row);
      retire      <= row.ret;
      irq         <= row.irq;
      curExpRaise <= row.expRaise;
      netReady    <= row.gaps ? (($random(seed) & 3) != 0) : 1'b1;
      if (row.csrNew) begin
         for (int i = 0; i < NUM_CSR; i++) begin
            csrIn[i] <= {32'($random(seed)), 32'($random(seed)), 32'($random(seed))};
         end
      end
   endtask

   //////////////////////////////////////////////////////////////
   // Output checks against the model
   //////////////////////////////////////////////////////////////
   task automatic checkOutputs();
      rvviPkg::netEventT exp;
      rvviPkg::csrIdxE   csrName;
      checkValue("trace_o.valid", traceOut.valid, expTrace.valid);
      if (expTrace.valid) begin
         checkValue("trace_o.order", traceOut.order, expTrace.order);
         checkValue("trace_o.insn", traceOut.insn, expTrace.insn);
         checkValue("trace_o.trap", traceOut.trap, expTrace.trap);
         checkValue("trace_o.intr", traceOut.intr, expTrace.intr);
         checkValue("trace_o.mode", traceOut.mode, expTrace.mode);
         checkValue("trace_o.ixl", traceOut.ixl, expTrace.ixl);
         checkValue("trace_o.pcRdata", traceOut.pcRdata, expTrace.pcRdata);
         checkValue("trace_o.pcWdata", traceOut.pcWdata, expTrace.pcWdata);
         checkValue("trace_o.xWb", traceOut.xWb, expTrace.xWb);
         checkValue("trace_o.xWdata", traceOut.xWdata, expTrace.xWdata);
      end
      for (int i = 0; i < NUM_CSR; i++) begin
         csrName = rvviPkg::csrIdxE'(i);
         checkValue($sformatf("csrValue_o[%s]", csrName.name()), csrValue[i], expCsr[i]);
      end
      checkValue("csrWb_o", csrWb, expWb);
      checkValue("netValid_o", netValid, expQ.size() != 0);
      // Payload must hold while the consumer stalls
      if (waiting) begin
         checkValue("netEvent_o", netEvent, heldEvent);
      end
      if (netValid && netReady) begin
         exp = expQ.pop_front();
         checkValue("netEvent_o.id", netEvent.id, exp.id);
         checkValue("netEvent_o.value", netEvent.value, exp.value);
      end
      waiting = netValid && !netReady;
      heldEvent = netEvent;
   endtask

   task automatic stepModel(input int occNow);
      logic              newRet;
      logic              halt;
      logic              nmi;
      logic              fault;
      logic [31:0]       cause;
      logic [31:0]       masked;
      logic [31:0]       merged;
      logic [4:0]        raise;
      logic [31:0]       val [NUM_NET];
      rvviPkg::netEventT ev;
      int                pick;
      if (rst_i === 1'b1) begin
         expTrace = '0;
         expWb = '0;
         for (int i = 0; i < NUM_CSR; i++) begin
            expCsr[i] = '0;
         end
         {mSeen, mHalt, mNmi, mFault} = '0;
         mLastOrder = '0;
         mCause = '0;
         mIrq = '0;
         mPend = '0;
         expQ.delete();
         waiting = 1'b0;
         modelLive = 1'b1;
      end else begin
         expTrace.valid   = retire.valid;
         expTrace.order   = retire.order;
         expTrace.insn    = retire.insn;
         expTrace.trap    = retire.trap.trap &&
                            (retire.trap.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);
         expTrace.intr    = retire.intr.intr;
         expTrace.mode    = retire.mode;
         expTrace.ixl     = retire.ixl;
         expTrace.pcRdata = retire.pcRdata;
         expTrace.pcWdata = retire.pcWdata;
         expTrace.xWb     = '0;
         if (retire.rd1Addr != 0) begin
            expTrace.xWb[retire.rd1Addr] = 1'b1;
         end
         expTrace.xWdata  = retire.rd1Wdata;
         if (retire.valid) begin
            for (int i = 0; i < NUM_CSR; i++) begin
               // Bit by bit, a set mask bit selects the written value
               for (int b = 0; b < 32; b++) begin
                  merged[b] = csrIn[i].wmask[b] ? csrIn[i].wdata[b] : csrIn[i].rdata[b];
               end
               expWb[i] = (merged != expCsr[i]);
               expCsr[i] = merged;
            end
         end
         // Net event kinds seen at this edge
         newRet = retire.valid && (!mSeen || (retire.order != mLastOrder));
         halt   = (retire.dbg == `RVVI_DBG_CAUSE_HALTREQ) && retire.dbgMode;
         cause  = 32'(retire.intr.cause);
         nmi    = (retire.intr.intr && retire.intr.interrupt &&
                   (cause == `RVVI_CAUSE_NMI_LOAD || cause == `RVVI_CAUSE_NMI_STORE)) ||
                  retire.nmip[0];
         fault  = retire.trap.trap && retire.trap.exception &&
                  (retire.trap.exceptionCause == `RVVI_CAUSE_IBUS_FAULT);
         masked = irq & `RVVI_IRQ_MASK;
         raise[rvviPkg::NET_HALTREQ]    = newRet && (halt != mHalt);
         raise[rvviPkg::NET_NMI_CAUSE]  = newRet && nmi && (cause != mCause);
         raise[rvviPkg::NET_NMI]        = newRet && (nmi != mNmi);
         raise[rvviPkg::NET_IBUS_FAULT] = newRet && (fault != mFault);
         raise[rvviPkg::NET_IRQ]        = (masked != mIrq);
         val[rvviPkg::NET_HALTREQ]      = 32'(halt);
         val[rvviPkg::NET_NMI_CAUSE]    = cause;
         val[rvviPkg::NET_NMI]          = 32'(nmi);
         val[rvviPkg::NET_IBUS_FAULT]   = 32'(fault);
         val[rvviPkg::NET_IRQ]          = masked;
         checkValue("raised net events", raise, curExpRaise);
         // Lowest pending kind enters the queue if there is room
         pick = -1;
         for (int i = NUM_NET - 1; i >= 0; i--) begin
            if (mPend[i]) begin
               pick = i;
            end
         end
         if (pick >= 0 && occNow < `RVVI_EVQ_DEPTH) begin
            ev.id = rvviPkg::netIdE'(pick);
            ev.value = mPendVal[pick];
            expQ.push_back(ev);
            mPend[pick] = 1'b0;
         end
         for (int i = 0; i < NUM_NET; i++) begin
            if (raise[i]) begin
               mPend[i] = 1'b1;
               mPendVal[i] = val[i];
            end
         end
         if (newRet) begin
            mSeen = 1'b1;
            mLastOrder = retire.order;
            mHalt = halt;
            mNmi = nmi;
            mFault = fault;
            if (nmi) begin
               mCause = cause;
            end
         end
         mIrq = masked;
      end
   endtask

   // Inputs and outputs are both settled at the falling edge
   always @(negedge rvvi) begin
      occ = expQ.size();
      if (modelLive) begin
         checkOutputs();
      end
      stepModel(occ);
   end

   always @(posedge rvvi) begin
      cycles = cycles + 1;
      if (cycles > timeoutLimit) begin
         reportFail($sformatf("Timeout after %0d cycles with events still expected", cycles));
      end
   end

   //////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////
   initial begin
      retire = '0;
      for (int i = 0; i < NUM_CSR; i++) begin
         csrIn[i] = '0;
      end
      irq = '0;
      netReady = 1'b0;
      curExpRaise = '0;
      buildTable();
      @(posedge rvvi);
      while (rst_i) begin
         @(posedge rvvi);
      end
      for (int n = 0; n < rows.size(); n++) begin
         driveRow(rows[n]);
         @(posedge rvvi);
      end
      retire <= '0;
      curExpRaise <= '0;
      // Drain the queue under random ready gaps
      while (expQ.size() != 0 || mPend != 0) begin
         netReady <= $random(seed) & 1;
         @(posedge rvvi);
      end
      repeat (3) @(posedge rvvi);
      @(negedge rvvi);
      if (expQ.size() == 0 && netValid === 1'b0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         reportFail("Net events were left over after the drain");
      end
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
src/rvviPkg.sv
src/retireTrace.sv
src/csrTrace.sv
src/eventMonitor.sv
src/netEventFifo.sv
src/rvviTraceTop.sv
tb/tbClock.sv
tb/rvviTraceTb.sv
